// ==== list.f ====
verilog/aluPkg.sv
verilog/integerUnit.sv
verilog/shiftUnit.sv
verilog/multiplyUnit.sv
verilog/divideUnit.sv
verilog/aluControl.sv
verilog/rvAlu.sv
tb/aluTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module aluTb -f list.f -o aluSim &&
./obj_dir/aluSim | tee /dev/stderr | grep -qx "sim passed" &&
echo "PASS" || { echo "FAIL"; exit 1; }

// ==== tb/aluTb.sv ====
// RV32IM ALU testbench
module aluTb;

  typedef struct packed {
    logic [63:0]    name;     // Up to 8 characters
    logic           opM;
    aluPkg::funct3T op;
    logic           opqual;
    aluPkg::wordT   in1;
    aluPkg::wordT   in2;
    aluPkg::wordT   expected;
  } vecT;

  localparam int numDirected = 35;
  localparam int numRandom   = 64;
  localparam int cycleLimit  = (numDirected + numRandom) * 40 + 100; // 40 cycles per vector

  logic           clk;
  logic           reset;
  aluPkg::aluReqT req;
  logic           wr;
  aluPkg::wordT   out;
  aluPkg::wordT   addrSum;
  logic           busy;

  vecT         directed [numDirected];
  logic [31:0] lfsr;
  int          cycles     = 0;

  rvAlu u_dut (
    .clk    (clk),
    .reset  (reset),
    .req    (req),
    .wr     (wr),
    .out    (out),
    .addrSum(addrSum),
    .busy   (busy)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Run length guard
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit) begin
      $display("Timeout after %0d cycles, the DUT never finished the tests", cycles);
      $display("sim failed");
      $fatal(1, "timeout");
    end
  end

  // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    lfsrNext = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit with MSB first
  task automatic drawBits(input int n, output aluPkg::wordT bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[30:0], lfsr[0]};
      lfsr = lfsrNext(lfsr);
    end
  endtask

  // Expected result straight from the RV32IM rules
  function automatic aluPkg::wordT refModel(input vecT v);
    logic signed [31:0] s1;
    logic signed [31:0] s2;
    logic signed [63:0] a;
    logic signed [63:0] b;
    logic [63:0]        p;
    logic [4:0]         sh;
    s1 = v.in1;
    s2 = v.in2;
    sh = v.in2[4:0]; // Only low 5 bits count
    refModel = '0;
    if (!v.opM) begin
      case (v.op)
        3'd0: refModel = v.opqual ? v.in1 - v.in2 : v.in1 + v.in2;
        3'd1: refModel = v.in1 << sh;
        3'd2: refModel = (s1 < s2) ? 32'd1 : 32'd0;
        3'd3: refModel = (v.in1 < v.in2) ? 32'd1 : 32'd0;
        3'd4: refModel = v.in1 ^ v.in2;
        3'd5: begin
          if (v.opqual) begin
            refModel = s1 >>> sh; // SRA
          end else begin
            refModel = v.in1 >> sh;
          end
        end
        3'd6: refModel = v.in1 | v.in2;
        default: refModel = v.in1 & v.in2;
      endcase
    end else if (!v.op[2]) begin
      // Zero-extend in1 for MULHU and in2 for MULHSU and MULHU
      a = (v.op == 3'd3) ? {32'd0, v.in1} : {{32{v.in1[31]}}, v.in1};
      b = v.op[1] ? {32'd0, v.in2} : {{32{v.in2[31]}}, v.in2};
      p = a * b;
      refModel = (v.op == 3'd0) ? p[31:0] : p[63:32];
    end else if (v.in2 == 32'd0) begin
      refModel = v.op[1] ? v.in1 : 32'hffff_ffff; // Divide by zero
    end else if (!v.op[0] && v.in1 == 32'h8000_0000 && v.in2 == 32'hffff_ffff) begin
      refModel = v.op[1] ? 32'd0 : v.in1;         // Signed overflow
    end else if (!v.op[0]) begin
      refModel = v.op[1] ? s1 % s2 : s1 / s2;
    end else begin
      refModel = v.op[1] ? v.in1 % v.in2 : v.in1 / v.in2;
    end
  endfunction

  task automatic checkValue(input logic [63:0] name, input string what,
                            input aluPkg::wordT expected, input aluPkg::wordT actual);
    if (actual !== expected) begin
      $display("Mismatch %0s %0s expected %h actual %h", name, what, expected, actual);
      $display("sim failed");
      $fatal(1, "check failed");
    end
  endtask

  // Directed vectors with hand-worked results
  task automatic loadTable();
    // Integer
    directed[0]  = '{"add",      1'b0, 3'd0, 1'b0, 32'h1234_5678, 32'h1111_1111, 32'h2345_6789};
    directed[1]  = '{"addWrap",  1'b0, 3'd0, 1'b0, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0000};
    directed[2]  = '{"sub",      1'b0, 3'd0, 1'b1, 32'h0000_0005, 32'h0000_0007, 32'hffff_fffe};
    directed[3]  = '{"sltNeg",   1'b0, 3'd2, 1'b0, 32'hffff_fffe, 32'h0000_0001, 32'h0000_0001};
    directed[4]  = '{"sltPos",   1'b0, 3'd2, 1'b0, 32'h0000_0007, 32'h8000_0000, 32'h0000_0000};
    directed[5]  = '{"sltu",     1'b0, 3'd3, 1'b0, 32'h0000_0001, 32'hffff_ffff, 32'h0000_0001};
    directed[6]  = '{"sltuEq",   1'b0, 3'd3, 1'b0, 32'h0000_0005, 32'h0000_0005, 32'h0000_0000};
    directed[7]  = '{"xor",      1'b0, 3'd4, 1'b0, 32'hf0f0_f0f0, 32'hff00_ff00, 32'h0ff0_0ff0};
    directed[8]  = '{"or",       1'b0, 3'd6, 1'b0, 32'hf0f0_0000, 32'h0000_0f0f, 32'hf0f0_0f0f};
    directed[9]  = '{"and",      1'b0, 3'd7, 1'b0, 32'hf0f0_f0f0, 32'hff00_ff00, 32'hf000_f000};
    // Shifts
    directed[10] = '{"sll0",     1'b0, 3'd1, 1'b0, 32'h8765_4321, 32'h0000_0000, 32'h8765_4321};
    directed[11] = '{"sll31",    1'b0, 3'd1, 1'b0, 32'h0000_0003, 32'h0000_001f, 32'h8000_0000};
    directed[12] = '{"sllMask",  1'b0, 3'd1, 1'b0, 32'h0000_0001, 32'h0000_0024, 32'h0000_0010};
    directed[13] = '{"srl31",    1'b0, 3'd5, 1'b0, 32'h8000_0000, 32'h0000_001f, 32'h0000_0001};
    directed[14] = '{"sra31",    1'b0, 3'd5, 1'b1, 32'h8000_0000, 32'h0000_001f, 32'hffff_ffff};
    directed[15] = '{"sraNeg",   1'b0, 3'd5, 1'b1, 32'hf000_0000, 32'h0000_0004, 32'hff00_0000};
    directed[16] = '{"sraPos",   1'b0, 3'd5, 1'b1, 32'h7000_0000, 32'h0000_0004, 32'h0700_0000};
    // Multiplies
    directed[17] = '{"mul",      1'b1, 3'd0, 1'b0, 32'h0000_0007, 32'hffff_fffd, 32'hffff_ffeb};
    directed[18] = '{"mulhNN",   1'b1, 3'd1, 1'b0, 32'hffff_ffff, 32'hffff_ffff, 32'h0000_0000};
    directed[19] = '{"mulhNP",   1'b1, 3'd1, 1'b0, 32'h8000_0000, 32'h0000_0002, 32'hffff_ffff};
    directed[20] = '{"mulhsu",   1'b1, 3'd2, 1'b0, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff};
    directed[21] = '{"mulhsuP",  1'b1, 3'd2, 1'b0, 32'h0000_0002, 32'h8000_0000, 32'h0000_0001};
    directed[22] = '{"mulhu",    1'b1, 3'd3, 1'b0, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_fffe};
    // Divides with zero divisor and overflow cases
    directed[23] = '{"div",      1'b1, 3'd4, 1'b0, 32'hffff_ffec, 32'h0000_0003, 32'hffff_fffa};
    directed[24] = '{"divu",     1'b1, 3'd5, 1'b0, 32'h0000_0014, 32'h0000_0003, 32'h0000_0006};
    directed[25] = '{"rem",      1'b1, 3'd6, 1'b0, 32'hffff_ffec, 32'h0000_0003, 32'hffff_fffe};
    directed[26] = '{"remu",     1'b1, 3'd7, 1'b0, 32'h0000_0014, 32'h0000_0003, 32'h0000_0002};
    directed[27] = '{"divNN",    1'b1, 3'd4, 1'b0, 32'hffff_fff9, 32'hffff_fffe, 32'h0000_0003};
    directed[28] = '{"remNegD",  1'b1, 3'd6, 1'b0, 32'h0000_0007, 32'hffff_fffe, 32'h0000_0001};
    directed[29] = '{"divZero",  1'b1, 3'd4, 1'b0, 32'h1234_5678, 32'h0000_0000, 32'hffff_ffff};
    directed[30] = '{"remZero",  1'b1, 3'd6, 1'b0, 32'hffff_fff0, 32'h0000_0000, 32'hffff_fff0};
    directed[31] = '{"divuZero", 1'b1, 3'd5, 1'b0, 32'h0000_0005, 32'h0000_0000, 32'hffff_ffff};
    directed[32] = '{"divOvf",   1'b1, 3'd4, 1'b0, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000};
    directed[33] = '{"remOvf",   1'b1, 3'd6, 1'b0, 32'h8000_0000, 32'hffff_ffff, 32'h0000_0000};
    directed[34] = '{"divuBig",  1'b1, 3'd5, 1'b0, 32'hffff_ffff, 32'h0000_0010, 32'h0fff_ffff};
  endtask

  // Apply one request and check out, addrSum and busy
  task automatic runVector(input vecT v);
    int   busyCycles;
    logic isDivide;
    logic isInteger;
    isDivide  = v.opM && v.op[2];
    isInteger = !v.opM && v.op != 3'd1 && v.op != 3'd5; // Not a shift
    @(posedge clk);
    req <= '{in1: v.in1, in2: v.in2, op: v.op, opqual: v.opqual, opM: v.opM};
    wr  <= 1'b1;
    @(negedge clk);
    checkValue(v.name, "addrSum", v.in1 + v.in2, addrSum);
    if (isInteger) checkValue(v.name, "out", v.expected, out); // Zero latency
    @(posedge clk);
    wr <= 1'b0;
    @(negedge clk);
    busyCycles = 0;
    while (busy) begin
      busyCycles++;
      @(negedge clk);
    end
    checkValue(v.name, "busy cycles", isDivide ? 32'd32 : 32'd0, 32'(busyCycles));
    checkValue(v.name, "out", v.expected, out);
    if (!isInteger) begin
      // New operands without wr leave the stored result alone
      @(posedge clk);
      req <= '{in1: ~v.in1, in2: ~v.in2, op: v.op, opqual: v.opqual, opM: v.opM};
      repeat (3) @(negedge clk);
      checkValue(v.name, "held out", v.expected, out);
    end
  endtask

  initial begin
    vecT          v;
    aluPkg::wordT bits;
    reset <= 1'b1;
    wr    <= 1'b0;
    req   <= '0;
    lfsr = 32'h5c8e;
    loadTable();
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    checkValue("reset", "busy", 32'd0, {31'd0, busy}); // Idle before any wr
    for (int i = 0; i < numDirected; i++) begin
      runVector(directed[i]);
    end
    for (int i = 0; i < numRandom; i++) begin
      v.name = "random";
      drawBits(1, bits);
      v.opM = bits[0];
      drawBits(3, bits);
      v.op = bits[2:0];
      drawBits(1, bits);
      v.opqual = bits[0];
      drawBits(32, bits);
      v.in1 = bits;
      drawBits(32, bits);
      v.in2 = bits;
      v.expected = refModel(v);
      runVector(v);
    end
    $display("sim passed");
    $finish;
  end

endmodule

// ==== verilog/aluControl.sv ====
// ALU control and result select
module aluControl (
  input  logic              clk,
  input  logic              reset,
  input  aluPkg::aluReqT    req,
  input  logic              wr,
  input  aluPkg::wordT      intResult,
  input  aluPkg::wordT      shiftResult,
  input  aluPkg::wordT      mulResult,
  input  aluPkg::divResultT divResult,
  input  logic              divLast,
  output logic              shiftLoad,
  output logic              mulLoad,
  output logic              divStart,
  output logic              busy,
  output aluPkg::wordT      out
);

  aluPkg::ctrlStateT state;
  aluPkg::ctrlStateT stateNext;
  aluPkg::resultSelT sel;
  logic              accept;

  // Operation class from opM and funct3
  always_comb begin
    sel = aluPkg::selInteger;
    if (req.opM) begin
      case (req.op)
        aluPkg::f3Mul,
        aluPkg::f3Mulh,
        aluPkg::f3Mulhsu,
        aluPkg::f3Mulhu: sel = aluPkg::selMultiply;
        aluPkg::f3Div,
        aluPkg::f3Divu:  sel = aluPkg::selQuotient;
        aluPkg::f3Rem,
        aluPkg::f3Remu:  sel = aluPkg::selRemainder;
        default:         sel = aluPkg::selInteger;
      endcase
    end else if (req.op == aluPkg::f3Sll || req.op == aluPkg::f3Srl) begin
      sel = aluPkg::selShift; // Registered barrel shift
    end
  end

  // Writes during a divide are dropped
  assign accept    = wr && (state == aluPkg::stIdle);
  assign shiftLoad = accept && (sel == aluPkg::selShift);
  assign mulLoad   = accept && (sel == aluPkg::selMultiply);
  assign divStart  = accept && (sel == aluPkg::selQuotient || sel == aluPkg::selRemainder);

  // Divide sequencing
  always_comb begin
    stateNext = state;
    case (state)
      aluPkg::stIdle: begin
        if (divStart) stateNext = aluPkg::stDivide;
      end
      aluPkg::stDivide: begin
        if (divLast) stateNext = aluPkg::stIdle; // 32nd step this edge
      end
      default: stateNext = aluPkg::stIdle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= aluPkg::stIdle;
    end else begin
      state <= stateNext;
    end
  end

  assign busy = (state == aluPkg::stDivide); // High exactly 32 cycles

  // Result mux
  always_comb begin
    case (sel)
      aluPkg::selShift:     out = shiftResult;
      aluPkg::selMultiply:  out = mulResult;
      aluPkg::selQuotient:  out = divResult.quotient;
      aluPkg::selRemainder: out = divResult.remainder;
      default:              out = intResult; // Combinational path
    endcase
  end

endmodule

// ==== verilog/aluPkg.sv ====
// RV32IM ALU shared types
package aluPkg;

  typedef logic [31:0] wordT;   // Operand or result word
  typedef logic [4:0]  shamtT;  // Shift amount
  typedef logic [2:0]  funct3T; // Instruction funct3 field

  // Base integer funct3 codes
  localparam funct3T f3AddSub = 3'b000;
  localparam funct3T f3Sll    = 3'b001;
  localparam funct3T f3Slt    = 3'b010;
  localparam funct3T f3Sltu   = 3'b011;
  localparam funct3T f3Xor    = 3'b100;
  localparam funct3T f3Srl    = 3'b101; // SRA too, opqual set
  localparam funct3T f3Or     = 3'b110;
  localparam funct3T f3And    = 3'b111;

  // RV32M funct3 codes
  localparam funct3T f3Mul    = 3'b000;
  localparam funct3T f3Mulh   = 3'b001;
  localparam funct3T f3Mulhsu = 3'b010;
  localparam funct3T f3Mulhu  = 3'b011;
  localparam funct3T f3Div    = 3'b100;
  localparam funct3T f3Divu   = 3'b101;
  localparam funct3T f3Rem    = 3'b110;
  localparam funct3T f3Remu   = 3'b111;

  // One ALU request
  typedef struct packed {
    wordT   in1;
    wordT   in2;
    funct3T op;
    logic   opqual; // SUB or SRA
    logic   opM;    // RV32M operation
  } aluReqT;

  // Which unit drives out
  typedef enum logic [2:0] {
    selInteger,
    selShift,
    selMultiply,
    selQuotient,
    selRemainder
  } resultSelT;

  typedef enum logic {stIdle, stDivide} ctrlStateT;

  // Divider outputs, signs already applied
  typedef struct packed {
    wordT quotient;
    wordT remainder;
  } divResultT;

endpackage

// ==== verilog/divideUnit.sv ====
// Restoring divider, one bit per cycle
module divideUnit (
  input  logic              clk,
  input  logic              reset,
  input  aluPkg::aluReqT    req,
  input  logic              divStart,
  output aluPkg::divResultT divResult,
  output logic              divLast
);

  aluPkg::wordT dividend;  // Partial remainder
  logic [62:0]  divisor;   // Shifted right each step
  aluPkg::wordT quotient;
  aluPkg::wordT quotMask;  // One-hot, current quotient bit
  logic         quotNeg;   // Negate quotient on output
  logic         remNeg;    // Negate remainder on output

  logic         signedOp;
  aluPkg::wordT absIn1;
  aluPkg::wordT absIn2;

  // DIV and REM take magnitudes
  assign signedOp = (req.op == aluPkg::f3Div) || (req.op == aluPkg::f3Rem);
  assign absIn1   = (signedOp && req.in1[31]) ? -req.in1 : req.in1;
  assign absIn2   = (signedOp && req.in2[31]) ? -req.in2 : req.in2;

  always_ff @(posedge clk) begin
    if (reset) begin
      dividend <= '0;
      divisor  <= '0;
      quotient <= '0;
      quotMask <= '0;
      quotNeg  <= 1'b0;
      remNeg   <= 1'b0;
    end else if (divStart) begin
      dividend <= absIn1;
      divisor  <= {absIn2, 31'd0}; // Aligned to quotient bit 31
      quotient <= '0;
      quotMask <= 32'h8000_0000;
      // Divide by zero keeps all-ones quotient positive
      quotNeg  <= signedOp && (req.in1[31] ^ req.in2[31]) && (|req.in2);
      remNeg   <= signedOp && req.in1[31]; // Remainder follows dividend
    end else if (|quotMask) begin
      // Subtract when it fits
      if (divisor <= {31'd0, dividend}) begin
        dividend <= dividend - divisor[31:0]; // Upper bits are zero here
        quotient <= quotient | quotMask;
      end
      divisor  <= divisor >> 1;
      quotMask <= quotMask >> 1;
    end
  end

  // Final step in progress
  assign divLast = quotMask[0];

  // Sign correction, dividend ends as remainder
  assign divResult.quotient  = quotNeg ? -quotient : quotient;
  assign divResult.remainder = remNeg ? -dividend : dividend;

endmodule

// ==== verilog/integerUnit.sv ====
// Integer add, compare and logic
module integerUnit (
  input  aluPkg::aluReqT req,
  output aluPkg::wordT   intResult,
  output aluPkg::wordT   addrSum
);

  logic [32:0] minus; // in1 - in2 with borrow in bit 32
  logic        lt;
  logic        ltu;

  // Address adder, also ADD
  assign addrSum = req.in1 + req.in2;

  // One 33-bit subtract serves SUB, SLT and SLTU
  assign minus = {1'b1, ~req.in2} + {1'b0, req.in1} + 33'd1;
  assign ltu   = minus[32];

  // Signs differ means in1 negative decides
  assign lt = (req.in1[31] ^ req.in2[31]) ? req.in1[31] : minus[32];

  always_comb begin
    case (req.op)
      aluPkg::f3AddSub: begin
        if (req.opqual) begin
          intResult = minus[31:0]; // SUB
        end else begin
          intResult = addrSum;     // ADD
        end
      end
      aluPkg::f3Slt:  intResult = {31'd0, lt};
      aluPkg::f3Sltu: intResult = {31'd0, ltu};
      aluPkg::f3Xor:  intResult = req.in1 ^ req.in2;
      aluPkg::f3Or:   intResult = req.in1 | req.in2;
      aluPkg::f3And:  intResult = req.in1 & req.in2;
      // Shift codes are served by shiftUnit
      default:        intResult = '0;
    endcase
  end

endmodule

// ==== verilog/multiplyUnit.sv ====
// Single-cycle 33x33 multiplier
module multiplyUnit (
  input  logic           clk,
  input  logic           reset,
  input  aluPkg::aluReqT req,
  input  logic           mulLoad,
  output aluPkg::wordT   mulResult
);

  logic               in1Unsigned;
  logic               in2Unsigned;
  logic signed [32:0] in1Ext;
  logic signed [32:0] in2Ext;
  logic signed [63:0] product;

  // MULHU both unsigned, MULHSU only in2
  assign in1Unsigned = (req.op == aluPkg::f3Mulhu);
  assign in2Unsigned = (req.op == aluPkg::f3Mulhsu) || (req.op == aluPkg::f3Mulhu);

  // Extra top bit is sign or zero
  assign in1Ext = {in1Unsigned ? 1'b0 : req.in1[31], req.in1};
  assign in2Ext = {in2Unsigned ? 1'b0 : req.in2[31], req.in2};

  // Signed product, only 64 bits needed
  assign product = in1Ext * in2Ext;

  always_ff @(posedge clk) begin
    if (reset) begin
      mulResult <= '0;
    end else if (mulLoad) begin
      if (req.op == aluPkg::f3Mul) begin
        mulResult <= product[31:0];  // Low word
      end else begin
        mulResult <= product[63:32]; // MULH, MULHSU, MULHU
      end
    end
  end

endmodule

// ==== verilog/rvAlu.sv ====
// RV32IM execute-stage ALU
module rvAlu (
  input  logic           clk,
  input  logic           reset,
  input  aluPkg::aluReqT req,
  input  logic           wr,
  output aluPkg::wordT   out,
  output aluPkg::wordT   addrSum,
  output logic           busy
);

  aluPkg::wordT      intResult;
  aluPkg::wordT      shiftResult;
  aluPkg::wordT      mulResult;
  aluPkg::divResultT divResult;
  logic              divLast;
  logic              shiftLoad;
  logic              mulLoad;
  logic              divStart;

  // Decode, divide FSM and output mux
  aluControl u_control (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .wr         (wr),
    .intResult  (intResult),
    .shiftResult(shiftResult),
    .mulResult  (mulResult),
    .divResult  (divResult),
    .divLast    (divLast),
    .shiftLoad  (shiftLoad),
    .mulLoad    (mulLoad),
    .divStart   (divStart),
    .busy       (busy),
    .out        (out)
  );

  integerUnit u_integer (
    .req      (req),
    .intResult(intResult),
    .addrSum  (addrSum) // Also used for address generation
  );

  shiftUnit u_shift (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .shiftLoad  (shiftLoad),
    .shiftResult(shiftResult)
  );

  multiplyUnit u_multiply (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .mulLoad  (mulLoad),
    .mulResult(mulResult)
  );

  divideUnit u_divide (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .divStart (divStart),
    .divResult(divResult),
    .divLast  (divLast)
  );

endmodule

// ==== verilog/shiftUnit.sv ====
// Registered barrel shifter
module shiftUnit (
  input  logic           clk,
  input  logic           reset,
  input  aluPkg::aluReqT req,
  input  logic           shiftLoad,
  output aluPkg::wordT   shiftResult
);

  aluPkg::shamtT shamt;
  logic          fill;       // Bit shifted in from the top
  aluPkg::wordT  rightShift;

  assign shamt = req.in2[4:0];
  assign fill  = req.opqual & req.in1[31]; // SRA keeps the sign

  // 33-bit arithmetic shift, fill bit picks SRL or SRA
  always_comb begin
    logic signed [32:0] wide;
    wide       = $signed({fill, req.in1}) >>> shamt;
    rightShift = wide[31:0];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      shiftResult <= '0;
    end else if (shiftLoad) begin
      if (req.op == aluPkg::f3Srl) begin
        shiftResult <= rightShift;
      end else begin
        shiftResult <= req.in1 << shamt; // SLL
      end
    end
  end

endmodule
